/* design/mister_pkg.sv */
// Frame wrapper shared definitions
package mister_pkg;

    // Host download byte address
    localparam int HPS_AW = 27;

    // DDR port geometry
    localparam int DDR_AW  = 29;
    localparam int DDR_BCW = 8;
    localparam int DDR_DW  = 64;
    // One enable per data byte
    localparam int DDR_BEW = DDR_DW / 8;

    // Sync offsets from the OSD status word, 0 to 15
    localparam int OFFW = 4;

    // Download index used by the host for ROM loads
    localparam logic [7:0] ROM_INDEX = 8'd0;

    // SDRAM programming word
    // Mask bits are active low, bit 1 covers the high byte
    typedef struct packed {
        logic [15:0] data;
        logic [1:0]  mask;
    } prog_word_t;

endpackage

/* design/ddr_req_if.sv */
// DDR request bundle
interface ddr_req_if;
    import mister_pkg::*;

    logic [DDR_BCW-1:0] burstcnt;
    logic [DDR_AW-1:0]  addr;
    logic               rd;
    logic               we;
    logic [DDR_BEW-1:0] be;
    // Request is taken when busy is low, held otherwise
    logic               busy;

    modport requester (
        output burstcnt, addr, rd, we, be,
        input  busy
    );

    modport arbiter (
        input  burstcnt, addr, rd, we, be,
        output busy
    );

endinterface

/* design/rom_dwnld.sv */
// ROM download to SDRAM programming words
module rom_dwnld #(
    parameter int SDRAMW = 23
)(
    input  logic                          clk_rom,
    input  logic                          rst,
    input  logic                          hps_download,
    input  logic [7:0]                    hps_index,
    input  logic                          hps_wr,
    input  logic [mister_pkg::HPS_AW-1:0] hps_addr,
    input  logic [7:0]                    hps_dout,
    input  logic                          prog_ready,
    output logic                          hps_wait,
    output logic                          prog_valid,
    output logic [SDRAMW-1:0]             prog_addr,
    output logic [15:0]                   prog_data,
    output logic [1:0]                    prog_mask,
    output logic                          downloading
);
    import mister_pkg::*;

    prog_word_t word;
    logic       rom_sel;
    logic       take;

    // Only the ROM index counts as a download here
    assign rom_sel = hps_download && (hps_index == ROM_INDEX);

    // New byte accepted only when no word is pending
    assign take = rom_sel && hps_wr && !prog_valid;

    always_ff @(posedge clk_rom) begin
        if (rst) begin
            downloading <= 1'b0;
            prog_valid  <= 1'b0;
        end else begin
            downloading <= rom_sel;
            if (take) begin
                prog_valid <= 1'b1;
            end else if (prog_valid && prog_ready) begin
                prog_valid <= 1'b0;
            end
        end
    end

    // Word capture, held while waiting for the handshake
    always_ff @(posedge clk_rom) begin
        if (take) begin
            word.data <= {hps_dout, hps_dout};
            // Odd byte address goes to the upper half
            word.mask <= hps_addr[0] ? 2'b01 : 2'b10;
            prog_addr <= hps_addr[SDRAMW:1];
        end
    end

    assign prog_data = word.data;
    assign prog_mask = word.mask;

    // Host holds off while a word waits
    assign hps_wait = prog_valid;

endmodule

/* design/sync_resync.sv */
// Sync pulse resynchronizer
module sync_resync (
    input  logic                        clk_rom,
    input  logic                        rst,
    input  logic                        pxl_cen,
    input  logic                        hs,
    input  logic                        vs,
    input  logic [mister_pkg::OFFW-1:0] hoffset,
    input  logic [mister_pkg::OFFW-1:0] voffset,
    output logic                        hs_out,
    output logic                        vs_out
);
    import mister_pkg::*;

    localparam int DEPTH = 2 ** OFFW;

    logic [DEPTH-1:0] hs_dly;
    logic [DEPTH-1:0] vs_dly;
    logic             hs_last;
    logic             hs_rise;

    // Line boundary, seen on pixel enables only
    assign hs_rise = hs && !hs_last;

    // Horizontal delay counted in pixels
    always_ff @(posedge clk_rom) begin
        if (rst) begin
            hs_dly  <= '0;
            hs_last <= 1'b0;
            hs_out  <= 1'b0;
        end else if (pxl_cen) begin
            hs_dly  <= {hs_dly[DEPTH-2:0], hs};
            hs_last <= hs;
            hs_out  <= hs_dly[hoffset];
        end
    end

    // Vertical delay counted in lines
    always_ff @(posedge clk_rom) begin
        if (rst) begin
            vs_dly <= '0;
            vs_out <= 1'b0;
        end else if (pxl_cen && hs_rise) begin
            vs_dly <= {vs_dly[DEPTH-2:0], vs};
            vs_out <= vs_dly[voffset];
        end
    end

endmodule

/* design/ddr_mux.sv */
// DDR port arbiter
module ddr_mux (
    input  logic                           clk_rom,
    input  logic                           rst,
    input  logic                           downloading,
    input  logic                           ddr_busy,
    ddr_req_if.arbiter                     ld,
    ddr_req_if.arbiter                     rot,
    output logic [mister_pkg::DDR_BCW-1:0] ddr_burstcnt,
    output logic [mister_pkg::DDR_AW-1:0]  ddr_addr,
    output logic                           ddr_rd,
    output logic                           ddr_we,
    output logic [mister_pkg::DDR_BEW-1:0] ddr_be
);

    logic ld_own;
    logic owner_idle;

    assign owner_idle = ld_own ? !(ld.rd || ld.we) : !(rot.rd || rot.we);

    // Ownership follows the download flag, switching only between requests
    always_ff @(posedge clk_rom) begin
        if (rst) begin
            ld_own <= 1'b0;
        end else if (owner_idle) begin
            ld_own <= downloading;
        end
    end

    always_comb begin
        if (ld_own) begin
            ddr_burstcnt = ld.burstcnt;
            ddr_addr     = ld.addr;
            ddr_rd       = ld.rd;
            ddr_we       = ld.we;
            ddr_be       = ld.be;
            ld.busy      = ddr_busy;
            rot.busy     = 1'b1;
        end else begin
            ddr_burstcnt = rot.burstcnt;
            ddr_addr     = rot.addr;
            ddr_rd       = rot.rd;
            ddr_we       = rot.we;
            ddr_be       = rot.be;
            ld.busy      = 1'b1;
            rot.busy     = ddr_busy;
        end
    end

endmodule

/* design/mister_frame.sv */
// Game frame wrapper top level
module mister_frame #(
    parameter int SDRAMW = 23
)(
    input  logic                           clk_rom,
    input  logic                           rst,
    input  logic [31:0]                    status,
    input  logic                           hps_download,
    input  logic [7:0]                     hps_index,
    input  logic                           hps_wr,
    input  logic [mister_pkg::HPS_AW-1:0]  hps_addr,
    input  logic [7:0]                     hps_dout,
    input  logic                           prog_ready,
    input  logic                           pxl_cen,
    input  logic                           hs,
    input  logic                           vs,
    input  logic [mister_pkg::DDR_BCW-1:0] ld_burstcnt,
    input  logic [mister_pkg::DDR_AW-1:0]  ld_addr,
    input  logic                           ld_rd,
    input  logic [mister_pkg::DDR_BCW-1:0] rot_burstcnt,
    input  logic [mister_pkg::DDR_AW-1:0]  rot_addr,
    input  logic                           rot_rd,
    input  logic                           rot_we,
    input  logic [mister_pkg::DDR_BEW-1:0] rot_be,
    input  logic                           ddr_busy,
    output logic                           hps_wait,
    output logic                           prog_valid,
    output logic [SDRAMW-1:0]              prog_addr,
    output logic [15:0]                    prog_data,
    output logic [1:0]                     prog_mask,
    output logic                           downloading,
    output logic                           hs_resync,
    output logic                           vs_resync,
    output logic                           ld_busy,
    output logic                           rot_busy,
    output logic [mister_pkg::DDR_BCW-1:0] ddr_burstcnt,
    output logic [mister_pkg::DDR_AW-1:0]  ddr_addr,
    output logic                           ddr_rd,
    output logic                           ddr_we,
    output logic [mister_pkg::DDR_BEW-1:0] ddr_be
);
    import mister_pkg::*;

    logic [OFFW-1:0] hoffset;
    logic [OFFW-1:0] voffset;

    ddr_req_if ld_bus();
    ddr_req_if rot_bus();

    // OSD offsets
    assign {voffset, hoffset} = status[31:24];

    // Fast loader only reads
    assign ld_bus.burstcnt = ld_burstcnt;
    assign ld_bus.addr     = ld_addr;
    assign ld_bus.rd       = ld_rd;
    assign ld_bus.we       = 1'b0;
    assign ld_bus.be       = '1;
    assign ld_busy         = ld_bus.busy;

    assign rot_bus.burstcnt = rot_burstcnt;
    assign rot_bus.addr     = rot_addr;
    assign rot_bus.rd       = rot_rd;
    assign rot_bus.we       = rot_we;
    assign rot_bus.be       = rot_be;
    assign rot_busy         = rot_bus.busy;

    rom_dwnld #(.SDRAMW(SDRAMW)) u_dwnld (
        .clk_rom      ( clk_rom      ),
        .rst          ( rst          ),
        .hps_download ( hps_download ),
        .hps_index    ( hps_index    ),
        .hps_wr       ( hps_wr       ),
        .hps_addr     ( hps_addr     ),
        .hps_dout     ( hps_dout     ),
        .prog_ready   ( prog_ready   ),
        .hps_wait     ( hps_wait     ),
        .prog_valid   ( prog_valid   ),
        .prog_addr    ( prog_addr    ),
        .prog_data    ( prog_data    ),
        .prog_mask    ( prog_mask    ),
        .downloading  ( downloading  )
    );

    sync_resync u_resync (
        .clk_rom ( clk_rom   ),
        .rst     ( rst       ),
        .pxl_cen ( pxl_cen   ),
        .hs      ( hs        ),
        .vs      ( vs        ),
        .hoffset ( hoffset   ),
        .voffset ( voffset   ),
        .hs_out  ( hs_resync ),
        .vs_out  ( vs_resync )
    );

    ddr_mux u_ddrmux (
        .clk_rom      ( clk_rom      ),
        .rst          ( rst          ),
        .downloading  ( downloading  ),
        .ddr_busy     ( ddr_busy     ),
        .ld           ( ld_bus       ),
        .rot          ( rot_bus      ),
        .ddr_burstcnt ( ddr_burstcnt ),
        .ddr_addr     ( ddr_addr     ),
        .ddr_rd       ( ddr_rd       ),
        .ddr_we       ( ddr_we       ),
        .ddr_be       ( ddr_be       )
    );

endmodule

/* verif/mister_frame_sva.sv */
// Download and DDR grant assertions
module mister_frame_sva #(
    parameter int PW = 1
)(
    input logic          clk_rom,
    input logic          rst,
    input logic          rom_wr,
    input logic          prog_valid,
    input logic          prog_ready,
    input logic [PW-1:0] prog_word,
    input logic          downloading,
    input logic          ddr_busy,
    input logic          ld_req,
    input logic          rot_req,
    input logic          ld_busy,
    input logic          rot_busy
);
    timeunit 1ns;
    timeprecision 100ps;

    int fail_count = 0;

    // Host must hold off while a word waits
    a_no_early_wr: assert property (@(posedge clk_rom) disable iff (rst)
        prog_valid |-> !rom_wr)
    else begin
        fail_count++;
        $error("host write arrived while a programming word was pending");
    end

    a_word_held: assert property (@(posedge clk_rom) disable iff (rst)
        prog_valid && !prog_ready |=> prog_valid && $stable(prog_word))
    else begin
        fail_count++;
        $error("programming word changed or dropped under back-pressure");
    end

    // Idle loader outside a download leaves the port to the rotator
    a_rot_granted: assert property (@(posedge clk_rom) disable iff (rst)
        !downloading && !ld_req |=> ld_busy && (rot_busy == ddr_busy))
    else begin
        fail_count++;
        $error("loader side saw busy low or rotator busy did not follow the DDR port");
    end

    // Idle rotator during a download leaves the port to the loader
    a_ld_granted: assert property (@(posedge clk_rom) disable iff (rst)
        downloading && !rot_req |=> rot_busy && (ld_busy == ddr_busy))
    else begin
        fail_count++;
        $error("rotator side saw busy low or loader busy did not follow the DDR port");
    end

endmodule

// Download checks, grant inputs tied off
bind rom_dwnld mister_frame_sva #(.PW(SDRAMW + 18)) u_dl_sva (
    .clk_rom     ( clk_rom           ),
    .rst         ( rst               ),
    .rom_wr      ( rom_sel && hps_wr ),
    .prog_valid  ( prog_valid        ),
    .prog_ready  ( prog_ready        ),
    .prog_word   ( {prog_addr, word} ),
    .downloading ( 1'b0              ),
    .ddr_busy    ( 1'b1              ),
    .ld_req      ( 1'b1              ),
    .rot_req     ( 1'b1              ),
    .ld_busy     ( 1'b1              ),
    .rot_busy    ( 1'b1              )
);

// Grant checks, download inputs tied idle
bind ddr_mux mister_frame_sva u_mux_sva (
    .clk_rom     ( clk_rom          ),
    .rst         ( rst              ),
    .rom_wr      ( 1'b0             ),
    .prog_valid  ( 1'b0             ),
    .prog_ready  ( 1'b0             ),
    .prog_word   ( 1'b0             ),
    .downloading ( downloading      ),
    .ddr_busy    ( ddr_busy         ),
    .ld_req      ( ld.rd || ld.we   ),
    .rot_req     ( rot.rd || rot.we ),
    .ld_busy     ( ld.busy          ),
    .rot_busy    ( rot.busy         )
);

/* verif/tb_mister_frame.sv */
// Frame wrapper testbench
module tb_mister_frame;
    timeunit 1ns;
    timeprecision 100ps;
    import mister_pkg::*;

    localparam int SDRAMW = 23;
    localparam int N_DL   = 10;
    localparam int N_OFF  = 4;

    logic clk_rom, rst, hps_download, hps_wr, prog_ready, pxl_cen, hs, vs;
    logic ld_rd, rot_rd, rot_we, ddr_busy;
    logic [31:0]        status;
    logic [7:0]         hps_index;
    logic [HPS_AW-1:0]  hps_addr;
    logic [7:0]         hps_dout;
    logic [DDR_BCW-1:0] ld_burstcnt;
    logic [DDR_AW-1:0]  ld_addr;
    logic [DDR_BCW-1:0] rot_burstcnt;
    logic [DDR_AW-1:0]  rot_addr;
    logic [DDR_BEW-1:0] rot_be;
    logic hps_wait, prog_valid, downloading, hs_resync, vs_resync;
    logic ld_busy, rot_busy, ddr_rd, ddr_we;
    logic [SDRAMW-1:0]  prog_addr;
    logic [15:0]        prog_data;
    logic [1:0]         prog_mask;
    logic [DDR_BCW-1:0] ddr_burstcnt;
    logic [DDR_AW-1:0]  ddr_addr;
    logic [DDR_BEW-1:0] ddr_be;

    // Download table as host index, byte address and byte
    logic [7:0] dl_index [N_DL] = '{8'h00, 8'h00, 8'h00, 8'h01, 8'h00,
                                    8'h00, 8'h02, 8'h00, 8'hff, 8'h00};
    logic [HPS_AW-1:0] dl_addr [N_DL] = '{27'h0000000, 27'h0000001, 27'h0000102,
        27'h0000010, 27'h4abcde7, 27'h7ffffff, 27'h0000020, 27'h0123456,
        27'h0000031, 27'h3000003};
    logic [7:0] dl_data  [N_DL] = '{8'h3c, 8'ha5, 8'h5a, 8'hff, 8'h81,
                                    8'h00, 8'h11, 8'hc3, 8'h77, 8'h5e};
    int         dl_stall [N_DL];
    // Offsets as {voffset, hoffset}, falling so an old pulse is already past the tap
    logic [7:0] off_tab  [N_OFF] = '{8'h9c, 8'h56, 8'h23, 8'h00};

    integer seed;
    int errors     = 0;
    int cycles     = 0;
    int limit      = 200;
    int xfer_count = 0;
    int rom_count  = 0;
    int stall_sum  = 0;
    int total;

    always #4 clk_rom = ~clk_rom;

    mister_frame #(.SDRAMW(SDRAMW)) UUT (.*);

    // Handshake count and run limit
    always @(posedge clk_rom) begin
        cycles++;
        if (!rst && prog_valid && prog_ready) begin
            xfer_count++;
        end
        if (cycles >= limit) begin
            $display("Timeout: run stopped after %0d cycles with tests unfinished", cycles);
            $display("** FAIL **");
            $finish;
        end
    end

    task automatic check_value(input string name, input logic [63:0] exp,
                               input logic [63:0] act);
        assert (act === exp) else begin
            errors++;
            $display("mismatch at %0t: %s expected %0h, actual %0h", $time, name, exp, act);
        end
    endtask

    // One pixel enable, then a cycle without
    task automatic pixel(input logic hs_v, input logic vs_v);
        @(negedge clk_rom);
        pxl_cen = 1'b1;
        hs      = hs_v;
        vs      = vs_v;
        @(negedge clk_rom);
        pxl_cen = 1'b0;
    endtask

    task automatic line(input logic vs_v);
        pixel(1'b1, vs_v);
        pixel(1'b0, 1'b0);
    endtask

    // Host byte, then the programming handshake after the stall cycles
    task automatic apply_entry(input int i);
        logic              is_rom;
        logic [HPS_AW-1:0] word_addr;
        is_rom    = (dl_index[i] == ROM_INDEX);
        word_addr = dl_addr[i] >> 1;
        @(negedge clk_rom);
        hps_download = 1'b1;
        hps_index    = dl_index[i];
        @(negedge clk_rom);
        check_value("downloading", 64'(is_rom), 64'(downloading));
        hps_wr   = 1'b1;
        hps_addr = dl_addr[i];
        hps_dout = dl_data[i];
        @(negedge clk_rom);
        hps_wr = 1'b0;
        if (is_rom) begin
            rom_count++;
            for (int s = 0; s <= dl_stall[i]; s++) begin
                check_value("hps_wait", 64'(1), 64'(hps_wait));
                check_value("prog_addr", 64'(word_addr[SDRAMW-1:0]), 64'(prog_addr));
                check_value("prog_data", 64'({dl_data[i], dl_data[i]}), 64'(prog_data));
                check_value("prog_mask", 64'({!dl_addr[i][0], dl_addr[i][0]}),
                            64'(prog_mask));
                prog_ready = (s == dl_stall[i]);
                @(negedge clk_rom);
            end
            prog_ready = 1'b0;
            check_value("prog_valid", 64'(0), 64'(prog_valid));
        end else begin
            repeat (3) begin
                @(negedge clk_rom);
                check_value("prog_valid", 64'(0), 64'(prog_valid));
                check_value("downloading", 64'(0), 64'(downloading));
            end
        end
        hps_download = 1'b0;
    endtask

    initial begin
        $timeformat(-9, 1, " ns", 0);
        clk_rom = 1'b0;
        rst     = 1'b1;
        {hps_download, hps_wr, prog_ready, pxl_cen, hs, vs} = '0;
        {ld_rd, rot_rd, rot_we, ddr_busy} = '0;
        {status, hps_index, hps_addr, hps_dout} = '0;
        {ld_burstcnt, ld_addr, rot_burstcnt, rot_addr, rot_be} = '0;
        seed = 32'hcdf0;
        for (int i = 0; i < N_DL; i++) begin
            dl_stall[i] = {$random(seed)} % 4;
            stall_sum += dl_stall[i];
        end
        limit = 10 * (N_DL + N_OFF + stall_sum) + 200;
        repeat (4) @(negedge clk_rom);
        rst = 1'b0;

        for (int i = 0; i < N_DL; i++) begin
            apply_entry(i);
        end
        check_value("handshake count", 64'(rom_count), 64'(xfer_count));

        // hs after hoffset + 1 enables, vs after voffset + 1 lines
        for (int t = 0; t < N_OFF; t++) begin
            status[31:24] = off_tab[t];
            // Push earlier line pulses past the hs tap
            repeat (off_tab[t][3:0] + 1) pixel(1'b0, 1'b0);
            pixel(1'b1, 1'b0);
            for (int i = 1; i <= off_tab[t][3:0] + 2; i++) begin
                pixel(1'b0, 1'b0);
                check_value("hs_resync", 64'(i == off_tab[t][3:0] + 1), 64'(hs_resync));
            end
            line(1'b1);
            for (int i = 1; i <= off_tab[t][7:4] + 2; i++) begin
                line(1'b0);
                check_value("vs_resync", 64'(i == off_tab[t][7:4] + 1), 64'(vs_resync));
            end
        end

        // Rotator owns the port outside a download
        rot_we      = 1'b1;
        rot_addr    = 29'h0a5a5a5;
        rot_be      = 8'hf0;
        ld_rd       = 1'b1;
        ld_addr     = 29'h1234567;
        ld_burstcnt = 8'd16;
        @(negedge clk_rom);
        check_value("ddr_addr", 64'(rot_addr), 64'(ddr_addr));
        check_value("ddr_be", 64'(8'hf0), 64'(ddr_be));
        check_value("ddr_we", 64'(1), 64'(ddr_we));
        check_value("ddr_rd", 64'(0), 64'(ddr_rd));
        check_value("ld_busy", 64'(1), 64'(ld_busy));
        check_value("rot_busy", 64'(0), 64'(rot_busy));
        ddr_busy     = 1'b1;
        hps_download = 1'b1;
        hps_index    = ROM_INDEX;
        repeat (2) @(negedge clk_rom);
        // Rotator request still pending, no handover yet
        check_value("downloading", 64'(1), 64'(downloading));
        check_value("rot_busy", 64'(1), 64'(rot_busy));
        check_value("ddr_addr", 64'(rot_addr), 64'(ddr_addr));
        rot_we   = 1'b0;
        ddr_busy = 1'b0;
        @(negedge clk_rom);
        check_value("ddr_addr", 64'(ld_addr), 64'(ddr_addr));
        check_value("ddr_burstcnt", 64'(16), 64'(ddr_burstcnt));
        check_value("ddr_rd", 64'(1), 64'(ddr_rd));
        check_value("ddr_we", 64'(0), 64'(ddr_we));
        check_value("ddr_be", 64'(8'hff), 64'(ddr_be));
        check_value("rot_busy", 64'(1), 64'(rot_busy));
        check_value("ld_busy", 64'(0), 64'(ld_busy));
        ddr_busy = 1'b1;
        @(negedge clk_rom);
        check_value("ld_busy", 64'(1), 64'(ld_busy));
        {hps_download, ld_rd, ddr_busy} = '0;
        repeat (2) @(negedge clk_rom);
        check_value("rot_busy", 64'(0), 64'(rot_busy));
        check_value("ld_busy", 64'(1), 64'(ld_busy));

        total = errors + UUT.u_dwnld.u_dl_sva.fail_count + UUT.u_ddrmux.u_mux_sva.fail_count;
        $display("Checks finished: %0d value errors, %0d assertion failures",
                 errors, total - errors);
        if (total == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

/* all.f */
design/mister_pkg.sv
design/ddr_req_if.sv
design/rom_dwnld.sv
design/sync_resync.sv
design/ddr_mux.sv
design/mister_frame.sv
verif/mister_frame_sva.sv
verif/tb_mister_frame.sv
